//--- cpu_wait_top.f
source/cpu_wait_pkg.sv
source/cen_frac_gen.sv
source/wait_ctrl.sv
source/miss_recover.sv
source/wait_stats.sv
source/wait_apb_regs.sv
source/cpu_wait_top.sv
dv/wait_checker.sv
dv/tb_cpu_wait.sv

//--- run_sim.sh
#!/bin/sh
# build the cpu wait testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu_wait \
    -f cpu_wait_top.f -o tb_cpu_wait
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_cpu_wait)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- dv/tb_cpu_wait.sv
////////////////////
// cpu wait subsystem testbench
// random ROM, device and bus stimulus, APB access, checker beside the DUT
////////////////////

`timescale 1ns/1ps

module tb_cpu_wait
    import cpu_wait_pkg::*;
();

    logic               clk = 1'b0;
    logic               rst_n;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [7:0]         paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               rom_cs;
    logic               rom_ok;
    logic [dev_cnt-1:0] dev_busy;
    logic               mreq_n;
    logic               iorq_n;
    logic               busak_n;
    logic               cen_out;
    logic               gate;

    int          chk_errs;
    int          tb_errs;
    // stimulus modes, set by the main sequence
    logic        boot_stall;
    logic        stim_on;
    logic        stall_on;
    logic [31:0] rng_b;
    logic [31:0] rng_c;
    // cycles left until rom_ok, -1 when no ROM access is open
    int          rom_wait;

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    cpu_wait_top DUT (
        .clk (clk), .rst_n (rst_n),
        .psel (psel), .penable (penable), .pwrite (pwrite),
        .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
        .rom_cs (rom_cs), .rom_ok (rom_ok), .dev_busy (dev_busy),
        .mreq_n (mreq_n), .iorq_n (iorq_n), .busak_n (busak_n),
        .cen_out (cen_out), .gate (gate)
    );

    wait_checker chk (
        .clk (clk), .rst_n (rst_n),
        .psel (psel), .penable (penable), .pwrite (pwrite),
        .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
        .rom_cs (rom_cs), .rom_ok (rom_ok), .dev_busy (dev_busy),
        .mreq_n (mreq_n), .iorq_n (iorq_n), .busak_n (busak_n),
        .cen_out (cen_out), .gate (gate), .err_cnt (chk_errs)
    );

    ////////////////////
    // CPU side stimulus, sole driver of the ROM, device and bus lines
    initial begin
        rng_b    = 32'd82;
        rom_wait = -1;
        // ROM access and device busy already pending across reset
        rom_cs   = 1'b1;
        rom_ok   = 1'b0;
        dev_busy = '1;
        mreq_n   = 1'b1;
        iorq_n   = 1'b1;
        busak_n  = 1'b1;
        forever begin
            @(posedge clk);
            if (boot_stall) begin
                // keep the reset-time stall
            end else if (!stim_on) begin
                rom_cs   <= 1'b0;
                rom_ok   <= 1'b0;
                dev_busy <= '0;
            end else begin
                rng_b = xorshift(rng_b);
                // bus idle in a bit more than half the cycles
                mreq_n  <= rng_b[16] | rng_b[17];
                iorq_n  <= |rng_b[20:18];
                busak_n <= |rng_b[23:21];
                if (!stall_on) begin
                    rom_cs   <= 1'b0;
                    rom_ok   <= 1'b0;
                    dev_busy <= '0;
                    rom_wait = -1;
                end else begin
                    dev_busy <= (rng_b[7:4] == 4'd0) ? rng_b[12 +: dev_cnt] : '0;
                    if (rom_wait < 0) begin
                        if (rng_b[3:0] == 4'd0) begin
                            // new access, data after 0 to 6 cycles
                            rom_wait = int'(rng_b[26:24]) % 7;
                            rom_cs <= 1'b1;
                            rom_ok <= (rom_wait == 0);
                        end
                    end else if (rom_ok) begin
                        rom_cs <= 1'b0;
                        rom_ok <= 1'b0;
                        rom_wait = -1;
                    end else begin
                        rom_wait = rom_wait - 1;
                        rom_ok <= (rom_wait == 0);
                    end
                end
            end
        end
    end

    ////////////////////
    // APB access, no wait states
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // generator off while num and den change, so the rate never exceeds one
    task automatic set_rate(input logic [7:0] num, input logic [7:0] den, input logic rec_on);
        apb_write(reg_ctrl, {30'd0, rec_on, 1'b0});
        apb_write(reg_num, 32'(num));
        apb_write(reg_den, 32'(den));
        apb_write(reg_ctrl, {30'd0, rec_on, 1'b1});
    endtask

    // reads over the whole map, unmapped 0x1C included
    task automatic random_reads(input int count);
        logic [31:0] rd;
        logic [7:0]  addr;
        int          gap;
        for (int i = 0; i < count; i++) begin
            rng_c = xorshift(rng_c);
            gap   = 1 + int'(rng_c[3:0]);
            addr  = {3'd0, rng_c[10:8], 2'b00};
            repeat (gap) @(posedge clk);
            apb_read(addr, rd);
        end
    endtask

    task automatic wait_gate_open(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!gate && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!gate) begin
            $display("ERROR: gate stayed closed for %0d cycles without a stall", limit);
            tb_errs++;
        end
    endtask

    // poll the owed count until recovery has paid it back
    task automatic drain_misses(input int limit);
        logic [31:0] rd;
        int          n;
        n = 0;
        apb_read(reg_miss, rd);
        while (rd != 32'd0 && n < limit) begin
            repeat (4) @(posedge clk);
            apb_read(reg_miss, rd);
            n++;
        end
        if (rd != 32'd0) begin
            $display("ERROR: missed enables were not recovered within %0d polls", limit);
            tb_errs++;
        end
    endtask

    ////////////////////
    // main sequence
    initial begin
        logic [31:0] rd;
        tb_errs    = 0;
        rng_c      = 32'd82;
        boot_stall = 1'b1;
        stim_on    = 1'b0;
        stall_on   = 1'b0;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // boot with a stall held, nothing may count as a miss
        repeat (3) @(posedge clk);
        boot_stall <= 1'b0;

        // register access, upper write bits dropped
        apb_write(reg_num, 32'h0000_0035);
        apb_write(reg_den, 32'hffff_ff60);
        apb_write(reg_ctrl, 32'h0000_0006);
        apb_read(reg_ctrl, rd);
        apb_read(reg_num, rd);
        apb_read(reg_den, rd);
        apb_read(8'h1C, rd);
        apb_read(8'h40, rd);
        apb_read(8'h03, rd);

        // enable rate without stalls
        stim_on <= 1'b1;
        set_rate(8'd1, 8'd1, 1'b1);
        repeat (30) @(posedge clk);
        set_rate(8'd1, 8'd4, 1'b1);
        repeat (40) @(posedge clk);
        set_rate(8'd3, 8'd7, 1'b1);
        repeat (40) @(posedge clk);
        set_rate(8'd5, 8'd8, 1'b1);
        repeat (40) @(posedge clk);

        // stalls with recovery, then with recovery off
        stall_on <= 1'b1;
        set_rate(8'd1, 8'd3, 1'b1);
        random_reads(40);
        apb_write(reg_ctrl, 32'h0000_0001);
        random_reads(30);

        // stalls gone, recovery pays back the owed enables
        apb_write(reg_ctrl, 32'h0000_0003);
        stall_on <= 1'b0;
        wait_gate_open(20);
        drain_misses(50);

        // statistics before and after a clear
        apb_read(reg_st_miss, rd);
        apb_read(reg_st_rec, rd);
        apb_read(reg_st_lock, rd);
        apb_write(reg_ctrl, 32'h0000_0007);
        apb_read(reg_st_miss, rd);
        apb_read(reg_st_rec, rd);
        apb_read(reg_st_lock, rd);
        apb_read(reg_ctrl, rd);

        repeat (4) @(posedge clk);
        $display("errors: checker=%0d testbench=%0d", chk_errs, tb_errs);
        if (chk_errs == 0 && tb_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- dv/wait_checker.sv
////////////////////
// wait subsystem checker
// cycle model of enable, gate, recovery, stats and registers
// compares the DUT ports on every falling edge
////////////////////

`timescale 1ns/1ps

module wait_checker
    import cpu_wait_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    input  logic [31:0]        prdata,
    input  logic               rom_cs,
    input  logic               rom_ok,
    input  logic [dev_cnt-1:0] dev_busy,
    input  logic               mreq_n,
    input  logic               iorq_n,
    input  logic               busak_n,
    input  logic               cen_out,
    input  logic               gate,
    output int                 err_cnt
);

    int errs = 0;

    // model state, mirrors what the DUT holds after the coming edge
    wait_cfg_t         m_cfg;
    logic [frac_w-1:0] m_acc;
    logic              m_nom;
    logic              m_last_cs;
    logic              m_started;
    logic              m_locked;
    logic              m_cen_l;
    logic              m_clear;
    logic [miss_w-1:0] m_cnt;
    // 0 misses, 1 recoveries, 2 locked cycles
    logic [stat_w-1:0] m_st [3];

    assign err_cnt = errs;

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("MISMATCH %s got=%h exp=%h at %0t", name, got, exp, $time);
        errs++;
    endtask

    // saturating event counter step
    function automatic logic [stat_w-1:0] bump(input logic [stat_w-1:0] cur, input logic ev);
        if (ev && cur != '1) begin
            return cur + 1'b1;
        end
        return cur;
    endfunction

    ////////////////////
    // inputs only move on the rising edge, so the falling edge sees a settled cycle
    always @(negedge clk) begin : model
        logic        stall;
        logic        exp_gate;
        logic        exp_cen;
        logic        miss;
        logic        rec;
        logic        wr;
        int          acc_next;
        logic [31:0] exp_rd;
        if (!rst_n) begin
            m_cfg     = '{cen_en: 1'b0, rec_allow: 1'b1, num: 8'd1, den: 8'd4};
            m_acc     = '0;
            m_nom     = 1'b0;
            m_last_cs = 1'b1;
            m_started = 1'b0;
            m_locked  = 1'b0;
            m_cen_l   = 1'b0;
            m_clear   = 1'b0;
            m_cnt     = '0;
            for (int i = 0; i < 3; i++) begin
                m_st[i] = '0;
            end
        end else begin
            // stall on a new ROM access, an unfinished one, or any busy device
            stall    = (rom_cs && !m_last_cs) || (rom_cs && !rom_ok) || (|dev_busy);
            exp_gate = !(stall || m_locked);
            miss     = m_nom && !exp_gate && m_started;
            rec      = m_cfg.rec_allow && (m_cnt != '0) && !m_nom && exp_gate
                       && mreq_n && iorq_n && busak_n && !m_cen_l;
            exp_cen  = (m_nom && exp_gate) || rec;
            wr       = psel && penable && pwrite;

            if (gate !== exp_gate) begin
                flag_mismatch("gate", 32'(gate), 32'(exp_gate));
            end
            if (cen_out !== exp_cen) begin
                flag_mismatch("cen_out", 32'(cen_out), 32'(exp_cen));
            end
            if (cen_out && !gate) begin
                $display("ERROR: an enable reached the CPU while the gate was closed at %0t",
                         $time);
                errs++;
            end

            // read data in the access phase
            if (psel && penable && !pwrite) begin
                case (paddr)
                    reg_ctrl:    exp_rd = {30'd0, m_cfg.rec_allow, m_cfg.cen_en};
                    reg_num:     exp_rd = 32'(m_cfg.num);
                    reg_den:     exp_rd = 32'(m_cfg.den);
                    reg_miss:    exp_rd = 32'(m_cnt);
                    reg_st_miss: exp_rd = 32'(m_st[0]);
                    reg_st_rec:  exp_rd = 32'(m_st[1]);
                    reg_st_lock: exp_rd = 32'(m_st[2]);
                    default:     exp_rd = '0;
                endcase
                if (prdata !== exp_rd) begin
                    flag_mismatch($sformatf("prdata[%02h]", paddr), prdata, exp_rd);
                end
            end

            ////////////////////
            // advance, every step reads only state not yet moved

            // statistics, a pending clear wins
            if (m_clear) begin
                for (int i = 0; i < 3; i++) begin
                    m_st[i] = '0;
                end
            end else begin
                m_st[0] = bump(m_st[0], miss);
                m_st[1] = bump(m_st[1], rec);
                m_st[2] = bump(m_st[2], m_locked && m_started);
            end

            // owed enables, held at zero before start
            if (!m_started) begin
                m_cnt = '0;
            end else if (miss) begin
                if (m_cnt != '1) begin
                    m_cnt = m_cnt + 1'b1;
                end
            end else if (rec) begin
                m_cnt = m_cnt - 1'b1;
            end
            m_cen_l = exp_cen;

            // fractional enable: add num, fire and subtract once den is reached
            acc_next = int'(m_acc) + int'(m_cfg.num);
            if (!m_cfg.cen_en) begin
                m_acc = '0;
                m_nom = 1'b0;
            end else if (acc_next >= int'(m_cfg.den)) begin
                m_acc = frac_w'(acc_next - int'(m_cfg.den));
                m_nom = 1'b1;
            end else begin
                m_acc = frac_w'(acc_next);
                m_nom = 1'b0;
            end

            // controller leaves boot on its first edge
            m_last_cs = rom_cs;
            m_locked  = stall;
            m_started = 1'b1;

            // register writes
            m_clear = wr && (paddr == reg_ctrl) && pwdata[2];
            if (wr) begin
                case (paddr)
                    reg_ctrl: begin
                        m_cfg.cen_en    = pwdata[0];
                        m_cfg.rec_allow = pwdata[1];
                    end
                    reg_num: m_cfg.num = pwdata[frac_w-1:0];
                    reg_den: m_cfg.den = pwdata[frac_w-1:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- source/cpu_wait_top.sv
////////////////////
// CPU clock-enable wait subsystem
// enable generator, wait FSM, recovery, stats and APB regs
////////////////////

`timescale 1ns/1ps

module cpu_wait_top
    import cpu_wait_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    // APB
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    // ROM slot and shared memories
    input  logic               rom_cs,
    input  logic               rom_ok,
    input  logic [dev_cnt-1:0] dev_busy,
    // CPU bus activity
    input  logic               mreq_n,
    input  logic               iorq_n,
    input  logic               busak_n,
    output logic               cen_out,
    output logic               gate
);

    wait_cfg_t         cfg;
    wait_evt_t         evt;
    logic              cen_nom;
    logic              started;
    logic              locked;
    logic              miss;
    logic              rec;
    logic              clear;
    logic [miss_w-1:0] miss_cnt;
    logic [stat_w-1:0] st_miss;
    logic [stat_w-1:0] st_rec;
    logic [stat_w-1:0] st_lock;

    // event bundle for the counters
    assign evt = '{miss: miss, rec: rec, locked: locked, started: started};

    cen_frac_gen u_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .cen_nom (cen_nom)
    );

    wait_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .dev_busy (dev_busy),
        .gate     (gate),
        .started  (started),
        .locked   (locked)
    );

    miss_recover u_rec (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .cen_nom  (cen_nom),
        .gate     (gate),
        .started  (started),
        .mreq_n   (mreq_n),
        .iorq_n   (iorq_n),
        .busak_n  (busak_n),
        .cen_out  (cen_out),
        .miss     (miss),
        .rec      (rec),
        .miss_cnt (miss_cnt)
    );

    wait_stats u_stats (
        .clk     (clk),
        .rst_n   (rst_n),
        .evt     (evt),
        .clear   (clear),
        .st_miss (st_miss),
        .st_rec  (st_rec),
        .st_lock (st_lock)
    );

    wait_apb_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .cfg      (cfg),
        .clear    (clear),
        .miss_cnt (miss_cnt),
        .st_miss  (st_miss),
        .st_rec   (st_rec),
        .st_lock  (st_lock)
    );

endmodule

//--- source/wait_apb_regs.sv
////////////////////
// APB register slave
// config registers, statistics clear pulse and read-back mux
// every transfer completes in its access phase
////////////////////

`timescale 1ns/1ps

module wait_apb_regs
    import cpu_wait_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [7:0]        paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output wait_cfg_t         cfg,
    output logic              clear,
    input  logic [miss_w-1:0] miss_cnt,
    input  logic [stat_w-1:0] st_miss,
    input  logic [stat_w-1:0] st_rec,
    input  logic [stat_w-1:0] st_lock
);

    logic wr;

    // write lands on the edge closing the access phase
    assign wr = psel & penable & pwrite;

    ////////////////////
    // write side

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= cfg_rst;
        end else if (wr) begin
            case (paddr)
                reg_ctrl: begin
                    cfg.cen_en    <= pwdata[0];
                    cfg.rec_allow <= pwdata[1];
                end
                reg_num: cfg.num <= pwdata[frac_w-1:0];
                reg_den: cfg.den <= pwdata[frac_w-1:0];
                // read-only and unmapped addresses drop the write
                default: ;
            endcase
        end
    end

    // self-clearing, high for the one cycle after the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clear <= 1'b0;
        end else begin
            clear <= wr && (paddr == reg_ctrl) && pwdata[2];
        end
    end

    ////////////////////
    // read side, zero-extended

    always_comb begin
        prdata = '0;
        case (paddr)
            reg_ctrl:    prdata[1:0]        = {cfg.rec_allow, cfg.cen_en};
            reg_num:     prdata[frac_w-1:0] = cfg.num;
            reg_den:     prdata[frac_w-1:0] = cfg.den;
            reg_miss:    prdata[miss_w-1:0] = miss_cnt;
            reg_st_miss: prdata[stat_w-1:0] = st_miss;
            reg_st_rec:  prdata[stat_w-1:0] = st_rec;
            reg_st_lock: prdata[stat_w-1:0] = st_lock;
            default:     prdata = '0;
        endcase
    end

    // access phase only ever follows a setup phase
    a_apb_seq: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable |-> $past(psel && !penable));

endmodule

//--- source/wait_stats.sv
////////////////////
// wait statistics
// saturating counters of misses, recoveries and locked cycles
////////////////////

`timescale 1ns/1ps

module wait_stats
    import cpu_wait_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  wait_evt_t         evt,
    input  logic              clear,
    output logic [stat_w-1:0] st_miss,
    output logic [stat_w-1:0] st_rec,
    output logic [stat_w-1:0] st_lock
);

    // 0 miss, 1 recovery, 2 locked after start
    logic [2:0]        hit;
    logic [stat_w-1:0] cnt [3];

    // locked in boot is not a real stall of a running CPU
    assign hit = {evt.locked & evt.started, evt.rec, evt.miss};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                // clear wins over a same-cycle event
                if (clear) begin
                    cnt[i] <= '0;
                end else if (hit[i] && !(&cnt[i])) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign st_miss = cnt[0];
    assign st_rec  = cnt[1];
    assign st_lock = cnt[2];

endmodule

//--- source/miss_recover.sv
////////////////////
// missed-enable recovery
// counts enables swallowed by the gate and
// reinserts them on idle bus cycles, never back to back
////////////////////

`timescale 1ns/1ps

module miss_recover
    import cpu_wait_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  wait_cfg_t         cfg,
    input  logic              cen_nom,
    input  logic              gate,
    input  logic              started,
    input  logic              mreq_n,
    input  logic              iorq_n,
    input  logic              busak_n,
    output logic              cen_out,
    output logic              miss,
    output logic              rec,
    output logic [miss_w-1:0] miss_cnt
);

    logic bus_idle;
    // last cycle's enable, keeps two pulses apart
    logic cen_l;

    // CPU not touching memory, IO or bus grant
    assign bus_idle = mreq_n & iorq_n & busak_n;

    // swallowed enable, only counted once the controller has started
    assign miss = cen_nom & ~gate & started;

    // recovery slot: owed enables, free slot, open gate, quiet bus
    assign rec = cfg.rec_allow & (miss_cnt != '0) & ~cen_nom & gate & bus_idle & ~cen_l;

    assign cen_out = (cen_nom & gate) | rec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_l <= 1'b0;
        end else begin
            cen_l <= cen_out;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miss_cnt <= '0;
        end else if (!started) begin
            miss_cnt <= '0;
        end else if (miss) begin
            // misses past the top are dropped here
            if (!(&miss_cnt)) begin
                miss_cnt <= miss_cnt + 1'b1;
            end
        end else if (rec) begin
            miss_cnt <= miss_cnt - 1'b1;
        end
    end

    // a recovery never lands right behind another enable
    a_rec_spaced: assert property (@(posedge clk) disable iff (!rst_n)
        cen_out |=> !rec);

    // counter wraps neither at the top nor at the bottom
    a_no_wrap_hi: assert property (@(posedge clk) disable iff (!rst_n)
        started && (&miss_cnt) |=> miss_cnt != '0);
    a_no_wrap_lo: assert property (@(posedge clk) disable iff (!rst_n)
        started && (miss_cnt == '0) |=> !(&miss_cnt));

endmodule

//--- source/wait_ctrl.sv
////////////////////
// wait controller
// turns ROM and shared-memory stalls into the enable gate
// holds the gate one extra cycle after a stall clears
////////////////////

`timescale 1ns/1ps

module wait_ctrl
    import cpu_wait_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rom_cs,
    input  logic               rom_ok,
    input  logic [dev_cnt-1:0] dev_busy,
    output logic               gate,
    output logic               started,
    output logic               locked
);

    wait_state_e state;
    wait_state_e state_nxt;
    logic        last_rom_cs;
    logic        rom_rise;
    logic        stall;

    ////////////////////
    // stall detection

    // a fresh ROM access is always a stall, rom_ok may still be stale
    assign rom_rise = rom_cs & ~last_rom_cs;
    assign stall    = rom_rise | (rom_cs & ~rom_ok) | (|dev_busy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // set so a rom_cs held high through reset is no edge
            last_rom_cs <= 1'b1;
        end else begin
            last_rom_cs <= rom_cs;
        end
    end

    ////////////////////
    // state machine

    // any stall locks, any clean cycle runs
    always_comb begin
        if (stall) begin
            state_nxt = st_locked;
        end else begin
            state_nxt = st_run;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_boot;
        end else begin
            state <= state_nxt;
        end
    end

    assign locked  = (state == st_locked);
    assign started = (state != st_boot);
    // closed while stalled and for the locked cycle after
    assign gate    = ~(stall | locked);

    // boot is left for good once the first edge has passed
    a_no_reboot: assert property (@(posedge clk) disable iff (!rst_n)
        state != st_boot |=> state != st_boot);

endmodule

//--- source/cen_frac_gen.sv
////////////////////
// fractional clock-enable generator
// emits num/den evenly spaced one-cycle enables, registered
////////////////////

`timescale 1ns/1ps

module cen_frac_gen
    import cpu_wait_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  wait_cfg_t cfg,
    output logic      cen_nom
);

    // phase accumulator, stays below den in steady state
    logic [frac_w-1:0] acc;
    // one extra bit so acc + num never overflows
    logic [frac_w:0]   sum;
    logic              hit;

    assign sum = {1'b0, acc} + {1'b0, cfg.num};
    assign hit = sum >= {1'b0, cfg.den};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc     <= '0;
            cen_nom <= 1'b0;
        end else if (!cfg.cen_en) begin
            // generator off, phase restarts from zero
            acc     <= '0;
            cen_nom <= 1'b0;
        end else if (hit) begin
            // wrap around den and fire next cycle
            acc     <= frac_w'(sum - {1'b0, cfg.den});
            cen_nom <= 1'b1;
        end else begin
            acc     <= sum[frac_w-1:0];
            cen_nom <= 1'b0;
        end
    end

    // rate above one or divide by zero makes no sense for a clock enable
    a_rate_ok: assert property (@(posedge clk) disable iff (!rst_n)
        cfg.cen_en |-> (cfg.den != '0) && (cfg.den >= cfg.num));

endmodule

//--- source/cpu_wait_pkg.sv
////////////////////
// cpu wait subsystem shared definitions
// sizes, APB register map, wait FSM state and the config/event bundles
////////////////////

package cpu_wait_pkg;

    // number of shared-memory busy lines
    localparam int dev_cnt = 2;
    // missed-enable counter width, saturates at 15
    localparam int miss_w = 4;
    // statistics counter width, saturating
    localparam int stat_w = 16;
    // numerator / denominator width for the enable generator
    localparam int frac_w = 8;

    ////////////////////
    // register map, byte addresses
    localparam logic [7:0] reg_ctrl    = 8'h00;
    localparam logic [7:0] reg_num     = 8'h04;
    localparam logic [7:0] reg_den     = 8'h08;
    localparam logic [7:0] reg_miss    = 8'h0C;
    localparam logic [7:0] reg_st_miss = 8'h10;
    localparam logic [7:0] reg_st_rec  = 8'h14;
    localparam logic [7:0] reg_st_lock = 8'h18;

    // wait controller states
    typedef enum logic [1:0] {
        st_boot   = 2'd0,   // bus never free yet
        st_run    = 2'd1,   // bus free
        st_locked = 2'd2    // stall held one more cycle
    } wait_state_e;

    // configuration from the APB slave
    typedef struct packed {
        logic              cen_en;
        logic              rec_allow;
        logic [frac_w-1:0] num;
        logic [frac_w-1:0] den;
    } wait_cfg_t;

    // per-cycle events for the statistics block
    typedef struct packed {
        logic miss;
        logic rec;
        logic locked;
        logic started;
    } wait_evt_t;

    // config after reset: generator off, recovery on, rate 1/4
    localparam wait_cfg_t cfg_rst = '{cen_en: 1'b0, rec_allow: 1'b1, num: 8'd1, den: 8'd4};

endpackage
